// ==== hdl/icache_cfg_pkg.sv ====
// Cache geometry and the width types derived from it.
// Shared by every RTL block of the lookup pipeline.

`default_nettype none

package icache_cfg_pkg;

  // Geometry
  localparam int unsigned FETCH_AW    = 32;
  localparam int unsigned ID_WIDTH    = 4;
  localparam int unsigned LINE_WIDTH  = 128;
  localparam int unsigned LINE_COUNT  = 16;
  localparam int unsigned WAY_COUNT   = 2;
  localparam int unsigned LINE_ALIGN  = 4;
  localparam int unsigned COUNT_ALIGN = 4;
  localparam int unsigned SET_ALIGN   = 1;
  localparam int unsigned TAG_WIDTH   = FETCH_AW - LINE_ALIGN - COUNT_ALIGN;

  typedef logic [FETCH_AW-1:0]    addr_t;
  typedef logic [ID_WIDTH-1:0]    id_t;
  typedef logic [COUNT_ALIGN-1:0] index_t;
  typedef logic [SET_ALIGN-1:0]   way_t;
  typedef logic [TAG_WIDTH-1:0]   tag_t;
  typedef logic [LINE_WIDTH-1:0]  line_t;

  // One entry of the tag array
  typedef struct packed {
    logic valid;
    logic error;
    tag_t tag;
  } tag_entry_t;

endpackage

`default_nettype wire

// ==== hdl/icache_types_pkg.sv ====
// State and opcode encodings of the lookup pipeline.
// Used by the clear controller and the tag stage.

`default_nettype none

package icache_types_pkg;

  // Clear controller state
  typedef enum logic {
    INIT_CLEAR,
    INIT_READY
  } init_state_e;

  // Operation granted on the tag port in a cycle
  typedef enum logic [1:0] {
    TAG_OP_IDLE,
    TAG_OP_CLEAR,
    TAG_OP_REFILL,
    TAG_OP_LOOKUP
  } tag_op_e;

endpackage

`default_nettype wire

// ==== hdl/icache_init_ctrl.sv ====
// Sweeps all line indices after reset and after each flush strobe.
// While clearing_o is high the tag stage wipes one line per cycle.

`timescale 1ns/10ps
`default_nettype none

module icache_init_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  output logic                   clearing_o,
  output icache_cfg_pkg::index_t clear_index_o
);
  import icache_cfg_pkg::*;
  import icache_types_pkg::*;

  init_state_e state_q;
  index_t      count_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= INIT_CLEAR;
      count_q <= '0;
    end else if (flush_i) begin
      // A flush restarts the sweep from line zero
      state_q <= INIT_CLEAR;
      count_q <= '0;
    end else if (state_q == INIT_CLEAR) begin
      count_q <= count_q + 1'b1;
      if (count_q == index_t'(LINE_COUNT - 1)) begin
        state_q <= INIT_READY;
      end
    end
  end

  assign clearing_o    = (state_q == INIT_CLEAR);
  assign clear_index_o = count_q;

  a_flush_restarts : assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> clearing_o && (clear_index_o == '0));

endmodule

`default_nettype wire

// ==== hdl/icache_tag_stage.sv ====
// First pipeline stage: arbitrates the tag port, compares tags and holds the
// tag response in a fall-through buffer while the data stage stalls.

`timescale 1ns/10ps
`default_nettype none

module icache_tag_stage (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clearing_i,
  input  icache_cfg_pkg::index_t clear_index_i,
  input  icache_cfg_pkg::addr_t  in_addr_i,
  input  icache_cfg_pkg::id_t    in_id_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  icache_cfg_pkg::index_t write_addr_i,
  input  icache_cfg_pkg::way_t   write_set_i,
  input  icache_cfg_pkg::tag_t   write_tag_i,
  input  logic                   write_error_i,
  input  logic                   write_valid_i,
  output logic                   write_ready_o,
  input  logic                   refill_conflict_i,
  output logic                   tag_valid_o,
  output icache_cfg_pkg::addr_t  tag_addr_o,
  output icache_cfg_pkg::id_t    tag_id_o,
  output icache_cfg_pkg::way_t   tag_set_o,
  output logic                   tag_hit_o,
  output logic                   tag_error_o,
  input  logic                   tag_ready_i,
  output logic                   hit_event_o,
  output logic                   miss_event_o
);
  import icache_cfg_pkg::*;
  import icache_types_pkg::*;

  tag_op_e              tag_op;
  index_t               tag_index;
  logic [WAY_COUNT-1:0] tag_we;
  tag_entry_t           tag_wdata;
  tag_entry_t           tag_mem [WAY_COUNT][LINE_COUNT];
  tag_entry_t           tag_rdata_q [WAY_COUNT];

  logic                 req_ready;
  logic                 valid_q;
  logic                 req_handshake_q;
  addr_t                addr_q;
  id_t                  id_q;
  tag_t                 required_tag;
  logic [WAY_COUNT-1:0] line_hit;
  way_t                 rsp_set_s;
  way_t                 rsp_set_d;
  way_t                 rsp_set_q;
  logic                 rsp_hit_s;
  logic                 rsp_hit_d;
  logic                 rsp_hit_q;
  logic                 rsp_error_s;
  logic                 rsp_error_d;
  logic                 rsp_error_q;

  // ------------------------------
  // Tag port arbitration
  // ------------------------------
  assign req_ready     = !valid_q || tag_ready_i;
  assign in_ready_o    = !clearing_i && !write_valid_i && req_ready;
  assign write_ready_o = !clearing_i;

  always_comb begin
    tag_op          = TAG_OP_IDLE;
    tag_index       = in_addr_i[LINE_ALIGN +: COUNT_ALIGN];
    tag_we          = '0;
    tag_wdata.valid = 1'b1;
    tag_wdata.error = write_error_i;
    tag_wdata.tag   = write_tag_i;
    if (clearing_i) begin
      tag_op    = TAG_OP_CLEAR;
      tag_index = clear_index_i;
      tag_we    = '1;
      tag_wdata = '0;
    end else if (write_valid_i) begin
      tag_op    = TAG_OP_REFILL;
      tag_index = write_addr_i;
      tag_we    = WAY_COUNT'(1) << write_set_i;
    end else if (in_valid_i && req_ready) begin
      tag_op = TAG_OP_LOOKUP;
    end
  end

  // Tag array, synchronous read of all ways
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < WAY_COUNT; w++) begin
      if (tag_we[w]) begin
        tag_mem[w][tag_index] <= tag_wdata;
      end
      if (tag_op == TAG_OP_LOOKUP) begin
        tag_rdata_q[w] <= tag_mem[w][tag_index];
      end
    end
  end

  // ------------------------------
  // Stage register
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q         <= 1'b0;
      req_handshake_q <= 1'b0;
    end else begin
      req_handshake_q <= (tag_op == TAG_OP_LOOKUP);
      if (tag_op == TAG_OP_LOOKUP) begin
        valid_q <= 1'b1;
      end else if (tag_ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tag_op == TAG_OP_LOOKUP) begin
      addr_q <= in_addr_i;
      id_q   <= in_id_i;
    end
    rsp_set_q   <= rsp_set_d;
    rsp_hit_q   <= rsp_hit_d;
    rsp_error_q <= rsp_error_d;
  end

  // Compare, lowest matching way wins
  assign required_tag = addr_q[FETCH_AW-1 -: TAG_WIDTH];

  always_comb begin
    rsp_set_s   = '0;
    rsp_error_s = 1'b0;
    for (int w = WAY_COUNT - 1; w >= 0; w--) begin
      line_hit[w] = tag_rdata_q[w].valid && (tag_rdata_q[w].tag == required_tag);
      if (line_hit[w]) begin
        rsp_set_s   = way_t'(w);
        rsp_error_s = tag_rdata_q[w].error;
      end
    end
    rsp_hit_s = |line_hit;
  end

  // Fall-through buffer of the tag response
  always_comb begin
    rsp_set_d   = rsp_set_q;
    rsp_hit_d   = rsp_hit_q;
    rsp_error_d = rsp_error_q;
    if (req_handshake_q && !tag_ready_i) begin
      rsp_set_d   = rsp_set_s;
      rsp_hit_d   = rsp_hit_s;
      rsp_error_d = rsp_error_s;
    end
    // Refill overwrote the line we hit on
    if (refill_conflict_i) begin
      rsp_hit_d = 1'b0;
    end
  end

  assign tag_valid_o = valid_q;
  assign tag_addr_o  = addr_q;
  assign tag_id_o    = id_q;
  assign tag_set_o   = req_handshake_q ? rsp_set_s : rsp_set_q;
  assign tag_hit_o   = req_handshake_q ? rsp_hit_s : rsp_hit_q;
  assign tag_error_o = req_handshake_q ? rsp_error_s : rsp_error_q;

  assign hit_event_o  = req_handshake_q && rsp_hit_s;
  assign miss_event_o = req_handshake_q && !rsp_hit_s;

  // An accepted refill writes one way and never shares the port with a lookup
  a_refill_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (write_valid_i && write_ready_o) |-> $onehot(tag_we) && !(in_valid_i && in_ready_o));

endmodule

`default_nettype wire

// ==== hdl/icache_data_stage.sv ====
// Second pipeline stage: data array access, output register and read data
// buffer. Refills own the data port and stall the hand-over from the tag stage.

`timescale 1ns/10ps
`default_nettype none

module icache_data_stage (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clearing_i,
  input  logic                   tag_valid_i,
  input  icache_cfg_pkg::addr_t  tag_addr_i,
  input  icache_cfg_pkg::id_t    tag_id_i,
  input  icache_cfg_pkg::way_t   tag_set_i,
  input  logic                   tag_hit_i,
  input  logic                   tag_error_i,
  output logic                   tag_ready_o,
  input  icache_cfg_pkg::index_t write_addr_i,
  input  icache_cfg_pkg::way_t   write_set_i,
  input  icache_cfg_pkg::line_t  write_data_i,
  input  logic                   write_valid_i,
  output logic                   refill_conflict_o,
  output icache_cfg_pkg::addr_t  out_addr_o,
  output icache_cfg_pkg::id_t    out_id_o,
  output icache_cfg_pkg::way_t   out_set_o,
  output logic                   out_hit_o,
  output logic                   out_error_o,
  output icache_cfg_pkg::line_t  out_data_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i
);
  import icache_cfg_pkg::*;

  line_t  data_mem [WAY_COUNT][LINE_COUNT];
  line_t  rdata_q;
  line_t  data_rsp_q;
  index_t lookup_index;
  logic   data_write;
  logic   transfer;
  logic   valid_q;
  logic   tag_handshake_q;

  assign lookup_index = tag_addr_i[LINE_ALIGN +: COUNT_ALIGN];

  // Refill first, then the read of a hit
  assign data_write  = write_valid_i && !clearing_i;
  assign tag_ready_o = (!valid_q || out_ready_i) && !data_write;
  assign transfer    = tag_valid_i && tag_ready_o;

  assign refill_conflict_o = data_write && tag_valid_i &&
                             (write_set_i == tag_set_i) && (write_addr_i == lookup_index);

  always_ff @(posedge clk_i) begin
    if (data_write) begin
      data_mem[write_set_i][write_addr_i] <= write_data_i;
    end else if (transfer && tag_hit_i) begin
      rdata_q <= data_mem[tag_set_i][lookup_index];
    end
    if (transfer) begin
      out_addr_o  <= tag_addr_i;
      out_id_o    <= tag_id_i;
      out_set_o   <= tag_set_i;
      out_hit_o   <= tag_hit_i;
      out_error_o <= tag_error_i;
    end
    // Keep read data while the consumer stalls
    if (tag_handshake_q && !out_ready_i) begin
      data_rsp_q <= rdata_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q         <= 1'b0;
      tag_handshake_q <= 1'b0;
    end else begin
      tag_handshake_q <= transfer && tag_hit_i;
      if (transfer) begin
        valid_q <= 1'b1;
      end else if (out_ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  assign out_data_o  = tag_handshake_q ? rdata_q : data_rsp_q;
  assign out_valid_o = valid_q;

  a_rsp_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i |=> out_valid_o &&
      $stable(out_addr_o) && $stable(out_id_o) && $stable(out_set_o) &&
      $stable(out_hit_o) && $stable(out_error_o) &&
      (!out_hit_o || $stable(out_data_o)));

endmodule

`default_nettype wire

// ==== hdl/icache_lookup.sv ====
// Top level of the two-stage instruction cache lookup.
// Connects the clear controller, the tag stage and the data stage.

`timescale 1ns/10ps
`default_nettype none

module icache_lookup (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  icache_cfg_pkg::addr_t  in_addr_i,
  input  icache_cfg_pkg::id_t    in_id_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  icache_cfg_pkg::index_t write_addr_i,
  input  icache_cfg_pkg::way_t   write_set_i,
  input  icache_cfg_pkg::tag_t   write_tag_i,
  input  icache_cfg_pkg::line_t  write_data_i,
  input  logic                   write_error_i,
  input  logic                   write_valid_i,
  output logic                   write_ready_o,
  output icache_cfg_pkg::addr_t  out_addr_o,
  output icache_cfg_pkg::id_t    out_id_o,
  output icache_cfg_pkg::way_t   out_set_o,
  output logic                   out_hit_o,
  output logic                   out_error_o,
  output icache_cfg_pkg::line_t  out_data_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output logic                   hit_event_o,
  output logic                   miss_event_o
);
  import icache_cfg_pkg::*;

  logic   clearing;
  index_t clear_index;
  logic   tag_valid;
  addr_t  tag_addr;
  id_t    tag_id;
  way_t   tag_set;
  logic   tag_hit;
  logic   tag_error;
  logic   tag_ready;
  logic   refill_conflict;

  icache_init_ctrl u_init_ctrl (
    .clk_i, .rst_ni, .flush_i,
    .clearing_o    (clearing),
    .clear_index_o (clear_index)
  );

  icache_tag_stage u_tag_stage (
    .clk_i, .rst_ni,
    .clearing_i        (clearing),
    .clear_index_i     (clear_index),
    .in_addr_i, .in_id_i, .in_valid_i, .in_ready_o,
    .write_addr_i, .write_set_i, .write_tag_i, .write_error_i, .write_valid_i,
    .write_ready_o,
    .refill_conflict_i (refill_conflict),
    .tag_valid_o       (tag_valid),
    .tag_addr_o        (tag_addr),
    .tag_id_o          (tag_id),
    .tag_set_o         (tag_set),
    .tag_hit_o         (tag_hit),
    .tag_error_o       (tag_error),
    .tag_ready_i       (tag_ready),
    .hit_event_o, .miss_event_o
  );

  icache_data_stage u_data_stage (
    .clk_i, .rst_ni,
    .clearing_i        (clearing),
    .tag_valid_i       (tag_valid),
    .tag_addr_i        (tag_addr),
    .tag_id_i          (tag_id),
    .tag_set_i         (tag_set),
    .tag_hit_i         (tag_hit),
    .tag_error_i       (tag_error),
    .tag_ready_o       (tag_ready),
    .write_addr_i, .write_set_i, .write_data_i, .write_valid_i,
    .refill_conflict_o (refill_conflict),
    .out_addr_o, .out_id_o, .out_set_o, .out_hit_o, .out_error_o, .out_data_o,
    .out_valid_o, .out_ready_i
  );

endmodule

`default_nettype wire

// ==== verif/icache_tb_clk.sv ====
// Free-running clock of the testbench, 4 ns period.
// Starts high, so the first falling edge comes at 2 ns.

`timescale 1ns/10ps
`default_nettype none

module icache_tb_clk (
  output logic clk_o
);

  initial begin
    clk_o = 1'b1;
    forever begin
      #2 clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

// ==== verif/icache_lookup_tb.sv ====
// Testbench of the two-stage icache lookup pipeline.
// Runs the command file under verif/ against a model of the tag and data
// arrays and checks every response, the clear length and the event counts.

`timescale 1ns/10ps
`default_nettype none

module icache_lookup_tb;
  import icache_cfg_pkg::*;

  localparam int unsigned WAIT_LIMIT = 300;

  // One expected response, kept in request order
  typedef struct packed {
    addr_t       addr;
    id_t         id;
    way_t        set;
    logic        hit;
    logic        error;
    line_t       data;
    logic [31:0] accept_cycle;
    logic        strict;
  } expect_t;

  logic   clk;
  logic   rst_n;
  logic   flush;
  addr_t  in_addr;
  id_t    in_id;
  logic   in_valid;
  logic   in_ready;
  index_t write_addr;
  way_t   write_set;
  tag_t   write_tag;
  line_t  write_data;
  logic   write_error;
  logic   write_valid;
  logic   write_ready;
  addr_t  out_addr;
  id_t    out_id;
  way_t   out_set;
  logic   out_hit;
  logic   out_error;
  line_t  out_data;
  logic   out_valid;
  logic   out_ready;
  logic   hit_event;
  logic   miss_event;

  // Reference model of both arrays
  logic  model_valid [WAY_COUNT][LINE_COUNT];
  logic  model_error [WAY_COUNT][LINE_COUNT];
  tag_t  model_tag   [WAY_COUNT][LINE_COUNT];
  line_t model_data  [WAY_COUNT][LINE_COUNT];

  expect_t     exp_q [$];
  logic [31:0] cycle_cnt;
  logic [31:0] rng_state;
  logic        bp_on;
  logic        held_prev;
  logic        in_acc;
  logic        wr_acc;
  int unsigned hit_count;
  int unsigned miss_count;
  int unsigned hit_pulses;
  int unsigned miss_pulses;

  icache_tb_clk u_clk (.clk_o(clk));

  icache_lookup dut0 (
    .clk_i(clk), .rst_ni(rst_n), .flush_i(flush),
    .in_addr_i(in_addr), .in_id_i(in_id), .in_valid_i(in_valid), .in_ready_o(in_ready),
    .write_addr_i(write_addr), .write_set_i(write_set), .write_tag_i(write_tag),
    .write_data_i(write_data), .write_error_i(write_error),
    .write_valid_i(write_valid), .write_ready_o(write_ready),
    .out_addr_o(out_addr), .out_id_o(out_id), .out_set_o(out_set), .out_hit_o(out_hit),
    .out_error_o(out_error), .out_data_o(out_data),
    .out_valid_o(out_valid), .out_ready_i(out_ready),
    .hit_event_o(hit_event), .miss_event_o(miss_event)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] value);
    logic [31:0] x;
    x = value ^ (value << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // ------------------------------
  // Error reporting
  // ------------------------------
  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input line_t got, input line_t expected);
    if (got !== expected) begin
      report_error($sformatf("Mismatch at time %0t: %s is %0h, expected %0h",
                             $time, name, got, expected));
    end
  endtask

  // ------------------------------
  // Cycle driver and monitor
  // ------------------------------
  task automatic start_cycle();
    @(negedge clk);
    cycle_cnt   = cycle_cnt + 1;
    rng_state   = xorshift32(rng_state);
    out_ready   = bp_on ? rng_state[9] : 1'b1;
    in_valid    = 1'b0;
    write_valid = 1'b0;
    flush       = 1'b0;
  endtask

  // Samples one ns after the falling edge, well before the next rising edge
  task automatic end_cycle();
    expect_t front;
    #1;
    if (hit_event) hit_pulses++;
    if (miss_event) miss_pulses++;
    if (held_prev && !out_valid) begin
      report_error("out_valid_o dropped before the response was taken");
    end else if (out_valid && exp_q.size() == 0) begin
      report_error("response seen with no lookup outstanding");
    end else if (out_valid) begin
      front = exp_q[0];
      if (!held_prev && front.strict) begin
        check_value("response latency", line_t'(cycle_cnt - front.accept_cycle), line_t'(2));
      end
      check_value("out_addr_o", line_t'(out_addr), line_t'(front.addr));
      check_value("out_id_o", line_t'(out_id), line_t'(front.id));
      check_value("out_hit_o", line_t'(out_hit), line_t'(front.hit));
      if (front.hit) begin
        check_value("out_set_o", line_t'(out_set), line_t'(front.set));
        check_value("out_error_o", line_t'(out_error), line_t'(front.error));
        check_value("out_data_o", out_data, front.data);
      end
      if (out_ready) begin
        void'(exp_q.pop_front());
      end
    end
    held_prev = out_valid && !out_ready;
    in_acc    = in_valid && in_ready;
    wr_acc    = write_valid && write_ready;
  endtask

  task automatic drain_pipeline();
    int unsigned waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited == WAIT_LIMIT) begin
        report_error("outstanding lookups never completed");
      end else begin
        start_cycle();
        end_cycle();
        waited++;
      end
    end
  endtask

  // Counts the cycles in which the arrays refuse refills
  task automatic wait_clear(input int unsigned low_seen);
    int unsigned low_cycles;
    logic        ready_seen;
    low_cycles = low_seen;
    ready_seen = 1'b0;
    while (!ready_seen) begin
      if (low_cycles > WAIT_LIMIT) begin
        report_error("arrays never left the clear state");
      end else begin
        start_cycle();
        end_cycle();
        if (write_ready) begin
          ready_seen = 1'b1;
        end else begin
          check_value("in_ready_o", line_t'(in_ready), line_t'(0));
          low_cycles++;
        end
      end
    end
    check_value("clear length", line_t'(low_cycles), line_t'(LINE_COUNT));
    if (exp_q.size() == 0) begin
      check_value("in_ready_o", line_t'(in_ready), line_t'(1));
    end
  endtask

  // ------------------------------
  // Commands
  // ------------------------------
  task automatic issue_lookup(input addr_t addr, input id_t id);
    expect_t     item;
    index_t      idx;
    tag_t        tag;
    int unsigned waited;
    idx       = addr[LINE_ALIGN +: COUNT_ALIGN];
    tag       = addr[FETCH_AW-1 -: TAG_WIDTH];
    item      = '0;
    item.addr = addr;
    item.id   = id;
    // First valid way with a matching tag
    for (int w = 0; w < WAY_COUNT; w++) begin
      if (!item.hit && model_valid[w][idx] && model_tag[w][idx] == tag) begin
        item.hit   = 1'b1;
        item.set   = way_t'(w);
        item.error = model_error[w][idx];
        item.data  = model_data[w][idx];
      end
    end
    in_acc = 1'b0;
    waited = 0;
    while (!in_acc) begin
      if (waited == WAIT_LIMIT) begin
        report_error("lookup was never accepted");
      end else begin
        start_cycle();
        in_valid = 1'b1;
        in_addr  = addr;
        in_id    = id;
        end_cycle();
        waited++;
      end
    end
    item.accept_cycle = cycle_cnt;
    item.strict       = !bp_on;
    exp_q.push_back(item);
    if (item.hit) hit_count++;
    else miss_count++;
  endtask

  task automatic issue_refill(input index_t idx, input way_t way, input tag_t tag,
                              input logic err);
    line_t       data;
    int unsigned waited;
    drain_pipeline();
    for (int k = 0; k < LINE_WIDTH / 32; k++) begin
      rng_state        = xorshift32(rng_state);
      data[k*32 +: 32] = rng_state;
    end
    wr_acc = 1'b0;
    waited = 0;
    while (!wr_acc) begin
      if (waited == WAIT_LIMIT) begin
        report_error("refill was never accepted");
      end else begin
        start_cycle();
        write_valid = 1'b1;
        write_addr  = idx;
        write_set   = way;
        write_tag   = tag;
        write_error = err;
        write_data  = data;
        end_cycle();
        waited++;
      end
    end
    model_valid[way][idx] = 1'b1;
    model_error[way][idx] = err;
    model_tag[way][idx]   = tag;
    model_data[way][idx]  = data;
  endtask

  task automatic issue_flush();
    start_cycle();
    flush = 1'b1;
    end_cycle();
    for (int w = 0; w < WAY_COUNT; w++) begin
      for (int i = 0; i < LINE_COUNT; i++) begin
        model_valid[w][i] = 1'b0;
      end
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    int               fd;
    int               n;
    logic             done;
    string            cmd;
    logic [8*120-1:0] line_buf;
    addr_t            f_addr;
    id_t              f_id;
    index_t           f_index;
    way_t             f_way;
    tag_t             f_tag;
    logic             f_flag;

    rst_n       = 1'b0;
    flush       = 1'b0;
    in_addr     = '0;
    in_id       = '0;
    in_valid    = 1'b0;
    write_addr  = '0;
    write_set   = '0;
    write_tag   = '0;
    write_data  = '0;
    write_error = 1'b0;
    write_valid = 1'b0;
    out_ready   = 1'b1;
    cycle_cnt   = '0;
    rng_state   = 32'hab67_d69e;
    bp_on       = 1'b0;
    held_prev   = 1'b0;
    hit_count   = 0;
    miss_count  = 0;
    hit_pulses  = 0;
    miss_pulses = 0;
    for (int w = 0; w < WAY_COUNT; w++) begin
      for (int i = 0; i < LINE_COUNT; i++) begin
        model_valid[w][i] = 1'b0;
        model_error[w][i] = 1'b0;
        model_tag[w][i]   = '0;
        model_data[w][i]  = '0;
      end
    end

    repeat (3) begin
      start_cycle();
      end_cycle();
      check_value("in_ready_o", line_t'(in_ready), line_t'(0));
    end
    // Release cycle is the first cycle of the clear
    start_cycle();
    rst_n = 1'b1;
    end_cycle();
    check_value("write_ready_o", line_t'(write_ready), line_t'(0));
    wait_clear(1);

    fd = $fopen("verif/icache_lookup_stim.txt", "r");
    if (fd == 0) begin
      report_error("cannot open the stimulus file");
    end
    done = 1'b0;
    while (!done) begin
      n = $fscanf(fd, "%s", cmd);
      if (n != 1) begin
        done = 1'b1;
      end else if (cmd == "#") begin
        n = $fgets(line_buf, fd);
      end else if (cmd == "L") begin
        n = $fscanf(fd, "%h %h", f_addr, f_id);
        if (n != 2) report_error("malformed lookup line in the stimulus file");
        issue_lookup(f_addr, f_id);
      end else if (cmd == "W") begin
        n = $fscanf(fd, "%h %h %h %h", f_index, f_way, f_tag, f_flag);
        if (n != 4) report_error("malformed refill line in the stimulus file");
        issue_refill(f_index, f_way, f_tag, f_flag);
      end else if (cmd == "B") begin
        n = $fscanf(fd, "%h", f_flag);
        if (n != 1) report_error("malformed back-pressure line in the stimulus file");
        drain_pipeline();
        bp_on = f_flag;
      end else if (cmd == "F") begin
        issue_flush();
      end else if (cmd == "C") begin
        wait_clear(0);
      end else begin
        report_error($sformatf("unknown command %s in the stimulus file", cmd));
      end
    end
    $fclose(fd);

    drain_pipeline();
    check_value("hit_event_o count", line_t'(hit_pulses), line_t'(hit_count));
    check_value("miss_event_o count", line_t'(miss_pulses), line_t'(miss_count));
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
hdl/icache_cfg_pkg.sv
hdl/icache_types_pkg.sv
hdl/icache_init_ctrl.sv
hdl/icache_tag_stage.sv
hdl/icache_data_stage.sv
hdl/icache_lookup.sv
verif/icache_tb_clk.sv
verif/icache_lookup_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the icache lookup testbench with Verilator and runs it.
# The exit status of the simulation gives pass or fail.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module icache_lookup_tb \
  -f list.f \
  -Mdir obj_dir \
  -o icache_lookup_sim

./obj_dir/icache_lookup_sim

// ==== verif/icache_lookup_stim.txt ====
# Columns: L addr id | W index way tag error | F | C | B backpressure_on
# Numbers are hex; refill line data comes from the testbench PRNG
L 00001000 1
L 00002010 2
L 0000a0f0 3
W 5 0 000123 0
L 00012350 4
W 5 1 000456 1
L 00045650 5
L 00012358 6
L 00078950 7
W 2 1 00abcd 0
L 00abcd20 8
B 1
L 00012350 9
L 00045650 a
L 00abcd24 b
L 00099920 c
L 0001235c d
B 0
L 00012350 e
L 00045650 f
L 00abcd20 0
F
C
L 00012350 1
L 00045650 2
W 5 0 000123 1
L 00012350 3
L 00045650 4
